/* Bender.yml */
package:
  name: spad

sources:
  - source/spad_pkg.sv
  - source/fifo_1r1w.sv
  - source/rr_arbiter.sv
  - source/spad_sram.sv
  - source/spad_scheduler.sv
  - source/spad_top.sv
  - target: simulation
    files:
      - dv/spad_chk.sv
      - dv/spad_tb.sv

/* compile.f */
source/spad_pkg.sv
source/fifo_1r1w.sv
source/rr_arbiter.sv
source/spad_sram.sv
source/spad_scheduler.sv
source/spad_top.sv
dv/spad_chk.sv
dv/spad_tb.sv

/* dv/spad_chk.sv */
/*
 * Protocol checker for the scratchpad subsystem
 * Concurrent assertions on the client handshakes, the scheduler grant,
 * the credit counters and the response push timing
 */

`default_nettype none

module spad_chk #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4,
    parameter int CRED_W     = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1
) (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic [NUM_PORTS-1:0] i_req_push,
    input logic [NUM_PORTS-1:0] i_req_full,
    input logic [NUM_PORTS-1:0] i_rsp_pop,
    input logic [NUM_PORTS-1:0] i_rsp_empty,
    input logic [NUM_PORTS-1:0] i_req_pop,
    input logic [NUM_PORTS-1:0] i_rsp_push,
    input logic                 i_spad_en,
    input logic [CRED_W-1:0]    i_credit [NUM_PORTS]
);

    // Count of failed assertions
    int unsigned fail_cnt = 0;

    // Scheduler pops at most one request FIFO per cycle
    assert property (@(posedge i_clk) disable iff (!i_rst_n) $onehot0(i_req_pop))
        else begin
            $error("scheduler granted more than one port");
            fail_cnt++;
        end

    // Load data only follows a scratchpad access
    assert property (@(posedge i_clk) disable iff (!i_rst_n) (|i_rsp_push) |-> $past(i_spad_en))
        else begin
            $error("response push without a scratchpad access in the cycle before");
            fail_cnt++;
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Client must respect o_req_full
        assert property (@(posedge i_clk) disable iff (!i_rst_n) i_req_push[p] |-> !i_req_full[p])
            else begin
                $error("request push into a full FIFO on port %0d", p);
                fail_cnt++;
            end

        // Client must respect o_rsp_empty
        assert property (@(posedge i_clk) disable iff (!i_rst_n) i_rsp_pop[p] |-> !i_rsp_empty[p])
            else begin
                $error("response pop from an empty FIFO on port %0d", p);
                fail_cnt++;
            end

        // Usable response FIFO capacity bounds the credits
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                         int'(i_credit[p]) <= FIFO_DEPTH - 1)
            else begin
                $error("credit counter above FIFO capacity on port %0d", p);
                fail_cnt++;
            end

        // A grant takes only one credit per cycle
        // A larger drop means the counter wrapped past its top
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
                         int'(i_credit[p]) + 1 >= int'($past(i_credit[p])))
            else begin
                $error("credit counter overflowed and wrapped on port %0d", p);
                fail_cnt++;
            end
    end

endmodule

bind spad_top spad_chk #(
    .NUM_PORTS  (NUM_PORTS),
    .FIFO_DEPTH (FIFO_DEPTH)
) chk_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_push  (i_req_push),
    .i_req_full  (o_req_full),
    .i_rsp_pop   (i_rsp_pop),
    .i_rsp_empty (o_rsp_empty),
    .i_req_pop   (req_pop),
    .i_rsp_push  (rsp_push),
    .i_spad_en   (spad_en),
    .i_credit    (sched_i.credit_q)
);

`default_nettype wire

/* dv/spad_tb.sv */
/*
 * Testbench for the shared scratchpad subsystem
 * Table-driven loads, stores and pops on two ports, checked against a
 * reference memory and per-port queues of expected responses
 */

`default_nettype none

module spad_tb;

    import spad_pkg::*;

    localparam int NUM_PORTS  = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int SPAD_WORDS = 64;
    // Cycles any single wait may take
    localparam int TIMEOUT    = 50;

    // Port masks used in the table
    localparam logic [1:0] P0   = 2'b01;
    localparam logic [1:0] P1   = 2'b10;
    // Both ports, port 1 goes to the upper half of the address space
    localparam logic [1:0] BOTH = 2'b11;

    typedef enum logic [1:0] {OP_IDLE, OP_LOAD, OP_STORE, OP_POP} op_e;

    typedef struct packed {
        logic [1:0] mask;
        op_e        op;
        spad_addr_t addr;
        spad_data_t data;
        // Store data from the LFSR instead of the data column
        logic       fill;
    } step_t;

    localparam int NUM_STEPS = 31;
    localparam step_t STEPS [NUM_STEPS] = '{
        // Port 0 stores, then loads back in push order
        '{P0, OP_STORE, 6'h10, 16'h0000, 1'b1},
        '{P0, OP_STORE, 6'h11, 16'h0000, 1'b1},
        '{P0, OP_STORE, 6'h12, 16'h0000, 1'b1},
        '{P0, OP_STORE, 6'h13, 16'ha5c3, 1'b0},
        '{P0, OP_LOAD,  6'h10, 16'h0000, 1'b0},
        '{P0, OP_LOAD,  6'h11, 16'h0000, 1'b0},
        '{P0, OP_LOAD,  6'h12, 16'h0000, 1'b0},
        '{P0, OP_LOAD,  6'h13, 16'h0000, 1'b0},
        '{P0, OP_POP,   6'h00, 16'h0000, 1'b0},
        '{P0, OP_POP,   6'h00, 16'h0000, 1'b0},
        // o_rsp must hold while nobody pops
        '{P0, OP_IDLE,  6'h00, 16'h0000, 1'b0},
        '{P0, OP_IDLE,  6'h00, 16'h0000, 1'b0},
        '{P0, OP_POP,   6'h00, 16'h0000, 1'b0},
        '{P0, OP_POP,   6'h00, 16'h0000, 1'b0},
        '{P0, OP_IDLE,  6'h00, 16'h0000, 1'b0},
        // Concurrent loads to disjoint preloaded ranges
        '{BOTH, OP_LOAD, 6'h01, 16'h0000, 1'b0},
        '{BOTH, OP_LOAD, 6'h02, 16'h0000, 1'b0},
        '{BOTH, OP_LOAD, 6'h03, 16'h0000, 1'b0},
        '{BOTH, OP_POP,  6'h00, 16'h0000, 1'b0},
        '{BOTH, OP_POP,  6'h00, 16'h0000, 1'b0},
        '{BOTH, OP_POP,  6'h00, 16'h0000, 1'b0},
        '{BOTH, OP_STORE, 6'h05, 16'h0000, 1'b1},
        '{BOTH, OP_LOAD, 6'h05, 16'h0000, 1'b0},
        '{BOTH, OP_POP,  6'h00, 16'h0000, 1'b0},
        // Port 1 store, fenced by its own load, then read by port 0
        '{P1, OP_STORE, 6'h30, 16'h0000, 1'b1},
        '{P1, OP_LOAD,  6'h30, 16'h0000, 1'b0},
        '{P1, OP_POP,   6'h00, 16'h0000, 1'b0},
        '{P0, OP_LOAD,  6'h30, 16'h0000, 1'b0},
        '{P0, OP_POP,   6'h00, 16'h0000, 1'b0},
        '{BOTH, OP_IDLE, 6'h00, 16'h0000, 1'b0},
        '{BOTH, OP_IDLE, 6'h00, 16'h0000, 1'b0}
    };

    logic                 clk;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] req_push;
    mem_req_t             req [NUM_PORTS];
    logic [NUM_PORTS-1:0] req_full;
    logic [NUM_PORTS-1:0] rsp_pop;
    logic [NUM_PORTS-1:0] rsp_empty;
    mem_rsp_t             rsp [NUM_PORTS];

    // Reference model state
    spad_data_t           ref_mem [SPAD_WORDS];
    mem_rsp_t             exp_q [NUM_PORTS][$];
    mem_rsp_t             last_rsp [NUM_PORTS];
    logic [NUM_PORTS-1:0] have_last;
    logic [15:0]          lfsr_state;
    int unsigned          err_cnt;
    int unsigned          total_err;

    spad_top #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH),
        .SPAD_WORDS (SPAD_WORDS)
    ) dut_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req_push  (req_push),
        .i_req       (req),
        .o_req_full  (req_full),
        .i_rsp_pop   (rsp_pop),
        .o_rsp_empty (rsp_empty),
        .o_rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // One LFSR step per data bit
    function automatic spad_data_t rand_word();
        spad_data_t w;
        w = '0;
        for (int i = 0; i < SPAD_DATA_W; i++) begin
            w          = {w[SPAD_DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    function automatic void check_eq(input string name, input logic [31:0] exp_val,
                                     input logic [31:0] got_val);
        assert (got_val === exp_val)
            else begin
                $display("FAIL %s expected %0h got %0h", name, exp_val, got_val);
                err_cnt++;
            end
    endfunction

    // Push one request on every port in the mask, updating the model
    task automatic push_req(input logic [1:0] mask, input logic wr, input spad_addr_t addr,
                            input spad_data_t data, input logic fill);
        int         n;
        spad_addr_t a;
        spad_data_t d;
        n = 0;
        while (n < TIMEOUT && (req_full & mask) != '0) begin
            @(negedge clk);
            n++;
        end
        assert (n < TIMEOUT)
            else begin
                $display("Request FIFO stayed full, port mask %b", mask);
                err_cnt++;
            end
        if (n >= TIMEOUT) begin
            return;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) begin
                a      = (p == 1 && mask == BOTH) ? (addr ^ 6'h20) : addr;
                d      = fill ? rand_word() : data;
                req[p] = '{write: wr, addr: a, wdata: d};
                if (wr) begin
                    ref_mem[a] = d;
                end else begin
                    exp_q[p].push_back('{rdata: ref_mem[a], addr: a});
                end
            end
        end
        req_push = mask;
        @(negedge clk);
        req_push = '0;
    endtask

    // Wait for data on every masked port, pop, check a cycle later
    task automatic pop_rsp(input logic [1:0] mask);
        int       n;
        mem_rsp_t exp_rsp;
        n = 0;
        while (n < TIMEOUT && (rsp_empty & mask) != '0) begin
            @(negedge clk);
            n++;
        end
        assert (n < TIMEOUT)
            else begin
                $display("No response arrived, port mask %b", mask);
                err_cnt++;
            end
        if (n >= TIMEOUT) begin
            return;
        end
        rsp_pop = mask;
        @(negedge clk);
        rsp_pop = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) begin
                assert (exp_q[p].size() != 0)
                    else begin
                        $display("Port %0d returned a response nobody asked for", p);
                        err_cnt++;
                    end
                if (exp_q[p].size() != 0) begin
                    exp_rsp = exp_q[p].pop_front();
                    check_eq($sformatf("o_rsp[%0d].rdata", p), exp_rsp.rdata, rsp[p].rdata);
                    check_eq($sformatf("o_rsp[%0d].addr", p), exp_rsp.addr, rsp[p].addr);
                    last_rsp[p]  = exp_rsp;
                    have_last[p] = 1'b1;
                end
            end
        end
    endtask

    // One quiet cycle, popped data must not move
    task automatic idle_cycle();
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (have_last[p]) begin
                check_eq($sformatf("o_rsp[%0d] held", p), last_rsp[p], rsp[p]);
            end
        end
    endtask

    // Port 1 stops popping, port 0 keeps working
    task automatic stall_port1();
        int         pushed;
        spad_addr_t a;
        pushed = 0;
        while (pushed < 4 * FIFO_DEPTH && !req_full[1]) begin
            a      = spad_addr_t'(6'h20 + pushed);
            req[1] = '{write: 1'b0, addr: a, wdata: '0};
            exp_q[1].push_back('{rdata: ref_mem[a], addr: a});
            req_push = P1;
            @(negedge clk);
            req_push = '0;
            pushed++;
        end
        assert (req_full[1])
            else begin
                $display("o_req_full[1] never rose while port 1 was stalled");
                err_cnt++;
            end
        // Credits cover the response FIFO, then the request FIFO fills
        check_eq("loads accepted on port 1", 2 * (FIFO_DEPTH - 1), pushed);
        push_req(P0, 1'b1, 6'h08, '0, 1'b1);
        push_req(P0, 1'b0, 6'h08, '0, 1'b0);
        pop_rsp(P0);
        check_eq("o_req_full[1]", 1, req_full[1]);
        check_eq("o_rsp_empty[1]", 0, rsp_empty[1]);
        repeat (pushed) begin
            pop_rsp(P1);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        req_push   = '0;
        rsp_pop    = '0;
        req[0]     = '0;
        req[1]     = '0;
        have_last  = '0;
        err_cnt    = 0;
        lfsr_state = 16'd3527;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("o_req_full", 0, req_full);
        check_eq("o_rsp_empty", 2'b11, rsp_empty);

        // Fill the whole scratchpad, then fence with an in-order load
        for (int a = 0; a < SPAD_WORDS; a++) begin
            push_req(P0, 1'b1, spad_addr_t'(a), '0, 1'b1);
        end
        push_req(P0, 1'b0, spad_addr_t'(SPAD_WORDS - 1), '0, 1'b0);
        pop_rsp(P0);

        for (int i = 0; i < NUM_STEPS; i++) begin
            case (STEPS[i].op)
                OP_STORE: push_req(STEPS[i].mask, 1'b1, STEPS[i].addr, STEPS[i].data,
                                   STEPS[i].fill);
                OP_LOAD:  push_req(STEPS[i].mask, 1'b0, STEPS[i].addr, STEPS[i].data, 1'b0);
                OP_POP:   pop_rsp(STEPS[i].mask);
                default:  idle_cycle();
            endcase
        end

        stall_port1();

        // Nothing may be left over on either side
        idle_cycle();
        check_eq("o_rsp_empty", 2'b11, rsp_empty);
        check_eq("o_req_full", 0, req_full);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (exp_q[p].size() == 0)
                else begin
                    $display("Port %0d still owes %0d responses", p, exp_q[p].size());
                    err_cnt++;
                end
        end

        total_err = err_cnt + dut_i.chk_i.fail_cnt;
        $display("Errors: %0d (checks %0d, assertions %0d)", total_err, err_cnt,
                 dut_i.chk_i.fail_cnt);
        if (total_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/fifo_1r1w.sv */
/*
 * Synchronous FIFO with a type-parameter payload
 * Flags follow a push or pop one cycle later, read data arrives one
 * cycle after a pop and holds until the next pop
 */

`default_nettype none

module fifo_1r1w #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     i_clk,
    input  logic     i_rst_n,

    // Write side
    input  logic     i_push,
    output logic     o_full,
    input  payload_t i_wdata,

    // Read side
    input  logic     i_pop,
    output logic     o_empty,
    output payload_t o_rdata
);

    // Pointer width of at least one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Payload storage
    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;

    // Wraparound increment for any depth
    always_comb begin
        wr_ptr_nxt = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
        rd_ptr_nxt = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
    end

    // Equal pointers mean empty
    assign o_empty = (wr_ptr_q == rd_ptr_q);
    // One slot stays free so full and empty differ
    assign o_full  = (wr_ptr_nxt == rd_ptr_q);

    // Pointer state
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= wr_ptr_nxt;
            end
            if (i_pop) begin
                rd_ptr_q <= rd_ptr_nxt;
            end
        end
    end

    // Storage write and registered read
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr_q] <= i_wdata;
        end
        // Read register only moves on a pop
        if (i_pop) begin
            o_rdata <= mem[rd_ptr_q];
        end
    end

endmodule

`default_nettype wire

/* source/rr_arbiter.sv */
/*
 * Round-robin arbiter
 * Combinational one-hot grant to the first requester at or after a
 * rotating priority pointer
 */

`default_nettype none

module rr_arbiter #(
    parameter int NUM_PORTS = 2
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic [NUM_PORTS-1:0] i_req,
    input  logic                 i_advance,
    output logic [NUM_PORTS-1:0] o_grant
);

    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // Port with the highest priority this cycle
    logic [IDX_W-1:0] ptr_q;
    // Index of the granted port
    logic [IDX_W-1:0] grant_idx;

    // Scan from the pointer, wrapping around the port list
    always_comb begin
        int unsigned cand;
        logic        found;
        o_grant   = '0;
        grant_idx = ptr_q;
        found     = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = (int'(ptr_q) + i) % NUM_PORTS;
            if (!found && i_req[cand]) begin
                found         = 1'b1;
                o_grant[cand] = 1'b1;
                grant_idx     = IDX_W'(cand);
            end
        end
    end

    // Served port drops to lowest priority
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ptr_q <= '0;
        end else if (i_advance && (|o_grant)) begin
            ptr_q <= (grant_idx == IDX_W'(NUM_PORTS - 1)) ? '0 : grant_idx + IDX_W'(1);
        end
    end

endmodule

`default_nettype wire

/* source/spad_pkg.sv */
/*
 * Scratchpad subsystem package
 * Word and address widths of the shared scratchpad, plus the request
 * and response payloads carried through the per-port FIFOs
 */

`default_nettype none

package spad_pkg;

    // Word address into the scratchpad
    localparam int SPAD_ADDR_W = 6;
    // Data word carried by loads and stores
    localparam int SPAD_DATA_W = 16;

    typedef logic [SPAD_ADDR_W-1:0] spad_addr_t;
    typedef logic [SPAD_DATA_W-1:0] spad_data_t;

    // Client request, one per push into a request FIFO
    typedef struct packed {
        // 1 = store, 0 = load
        logic       write;
        spad_addr_t addr;
        // Only meaningful for stores
        spad_data_t wdata;
    } mem_req_t;

    // Load response, one per load
    typedef struct packed {
        spad_data_t rdata;
        // Address of the load, lets the client match the response
        spad_addr_t addr;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* source/spad_scheduler.sv */
/*
 * Scratchpad request scheduler
 * Picks a request FIFO round-robin under per-port credits, issues the
 * access to the scratchpad and steers load data to the response FIFOs
 */

`default_nettype none

module spad_scheduler #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Request FIFOs
    input  logic [NUM_PORTS-1:0] i_req_empty,
    output logic [NUM_PORTS-1:0] o_req_pop,
    input  spad_pkg::mem_req_t   i_req_data [NUM_PORTS],

    // Client response pops, each returns a credit
    input  logic [NUM_PORTS-1:0] i_rsp_pop,

    // Scratchpad access
    output logic                 o_spad_en,
    output logic                 o_spad_we,
    output spad_pkg::spad_addr_t o_spad_addr,
    output spad_pkg::spad_data_t o_spad_wdata,
    input  spad_pkg::spad_data_t i_spad_rdata,

    // Response FIFOs
    output logic [NUM_PORTS-1:0] o_rsp_push,
    output spad_pkg::mem_rsp_t   o_rsp_data
);

    import spad_pkg::*;

    localparam int IDX_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    // Wide enough for FIFO_DEPTH-1
    localparam int CRED_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [IDX_W-1:0]  port_idx_t;
    typedef logic [CRED_W-1:0] credit_t;

    // What the read stage needs once the scratchpad answers
    typedef struct packed {
        logic       write;
        spad_addr_t addr;
        port_idx_t  port;
    } rd_stage_t;

    credit_t              credit_q [NUM_PORTS];
    credit_t              credit_d [NUM_PORTS];
    logic [NUM_PORTS-1:0] eligible;
    logic [NUM_PORTS-1:0] grant;
    logic [NUM_PORTS-1:0] refund;
    port_idx_t            grant_idx;

    // Issue stage, request data is on the FIFO output
    logic                 iss_valid_q;
    port_idx_t            iss_port_q;
    mem_req_t             iss_req;

    // Read stage, scratchpad data is on i_spad_rdata
    logic                 rd_valid_q;
    rd_stage_t            rd_q;

    // Port needs a queued request and room for a response
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            eligible[p] = !i_req_empty[p] && (credit_q[p] != '0);
        end
    end

    rr_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) arb_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_req     (eligible),
        .i_advance (|grant),
        .o_grant   (grant)
    );

    // Granted FIFO is popped in the same cycle
    assign o_req_pop = grant;

    // One-hot grant to index
    always_comb begin
        grant_idx = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (grant[p]) begin
                grant_idx = port_idx_t'(p);
            end
        end
    end

    // Popped request shows up one cycle after the pop
    assign iss_req      = i_req_data[iss_port_q];
    assign o_spad_en    = iss_valid_q;
    assign o_spad_we    = iss_req.write;
    assign o_spad_addr  = iss_req.addr;
    assign o_spad_wdata = iss_req.wdata;

    // Load data goes back to the issuing port only
    always_comb begin
        o_rsp_push = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rd_valid_q && !rd_q.write && (rd_q.port == port_idx_t'(p))) begin
                o_rsp_push[p] = 1'b1;
            end
        end
    end

    assign o_rsp_data = '{rdata: i_spad_rdata, addr: rd_q.addr};

    // Stores never produce a response, give the credit back at issue
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            refund[p] = iss_valid_q && iss_req.write && (iss_port_q == port_idx_t'(p));
        end
    end

    // Reserve on pop, refund on store, return on client pop
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            credit_d[p] = credit_q[p] + credit_t'(refund[p]) + credit_t'(i_rsp_pop[p])
                          - credit_t'(grant[p]);
        end
    end

    // Control state
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            iss_valid_q <= 1'b0;
            rd_valid_q  <= 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                credit_q[p] <= credit_t'(FIFO_DEPTH - 1);
            end
        end else begin
            iss_valid_q <= |grant;
            rd_valid_q  <= iss_valid_q;
            credit_q    <= credit_d;
        end
    end

    // Pipeline payload
    always_ff @(posedge i_clk) begin
        iss_port_q <= grant_idx;
        rd_q       <= '{write: iss_req.write, addr: iss_req.addr, port: iss_port_q};
    end

endmodule

`default_nettype wire

/* source/spad_sram.sv */
/*
 * Scratchpad array
 * Single-port synchronous RAM, one access per cycle, read data
 * registered and held until the next read
 */

`default_nettype none

module spad_sram #(
    parameter int SPAD_WORDS = 64
) (
    input  logic                 i_clk,
    input  logic                 i_en,
    input  logic                 i_we,
    input  spad_pkg::spad_addr_t i_addr,
    input  spad_pkg::spad_data_t i_wdata,
    output spad_pkg::spad_data_t o_rdata
);

    import spad_pkg::*;

    // Word array
    spad_data_t mem [SPAD_WORDS];

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                // Store
                mem[i_addr] <= i_wdata;
            end else begin
                // Load data visible on the next cycle
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* source/spad_top.sv */
/*
 * Shared scratchpad subsystem
 * Per-port request and response FIFOs around a round-robin scheduler
 * and a single-port scratchpad
 */

`default_nettype none

module spad_top #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4,
    parameter int SPAD_WORDS = 64
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,

    // Client request side
    input  logic [NUM_PORTS-1:0] i_req_push,
    input  spad_pkg::mem_req_t   i_req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] o_req_full,

    // Client response side
    input  logic [NUM_PORTS-1:0] i_rsp_pop,
    output logic [NUM_PORTS-1:0] o_rsp_empty,
    output spad_pkg::mem_rsp_t   o_rsp [NUM_PORTS]
);

    import spad_pkg::*;

    // Scheduler to FIFOs
    logic [NUM_PORTS-1:0] req_empty;
    logic [NUM_PORTS-1:0] req_pop;
    mem_req_t             req_rdata [NUM_PORTS];
    logic [NUM_PORTS-1:0] rsp_push;
    mem_rsp_t             rsp_data;

    // Scheduler to scratchpad
    logic                 spad_en;
    logic                 spad_we;
    spad_addr_t           spad_addr;
    spad_data_t           spad_wdata;
    spad_data_t           spad_rdata;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Requests from client p
        fifo_1r1w #(
            .payload_t (mem_req_t),
            .DEPTH     (FIFO_DEPTH)
        ) req_fifo_i (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_push  (i_req_push[p]),
            .o_full  (o_req_full[p]),
            .i_wdata (i_req[p]),
            .i_pop   (req_pop[p]),
            .o_empty (req_empty[p]),
            .o_rdata (req_rdata[p])
        );

        // Load responses to client p, all share one data bus
        fifo_1r1w #(
            .payload_t (mem_rsp_t),
            .DEPTH     (FIFO_DEPTH)
        ) rsp_fifo_i (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_push  (rsp_push[p]),
            .o_full  (),
            .i_wdata (rsp_data),
            .i_pop   (i_rsp_pop[p]),
            .o_empty (o_rsp_empty[p]),
            .o_rdata (o_rsp[p])
        );
    end

    spad_scheduler #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sched_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_empty  (req_empty),
        .o_req_pop    (req_pop),
        .i_req_data   (req_rdata),
        .i_rsp_pop    (i_rsp_pop),
        .o_spad_en    (spad_en),
        .o_spad_we    (spad_we),
        .o_spad_addr  (spad_addr),
        .o_spad_wdata (spad_wdata),
        .i_spad_rdata (spad_rdata),
        .o_rsp_push   (rsp_push),
        .o_rsp_data   (rsp_data)
    );

    spad_sram #(
        .SPAD_WORDS (SPAD_WORDS)
    ) sram_i (
        .i_clk   (i_clk),
        .i_en    (spad_en),
        .i_we    (spad_we),
        .i_addr  (spad_addr),
        .i_wdata (spad_wdata),
        .o_rdata (spad_rdata)
    );

endmodule

`default_nettype wire
